/* project.f */
src/uce_cache_pkg.sv
src/uce_mem_pkg.sv
src/uce_credit_counter.sv
src/uce_victim_buffer.sv
src/uce_fsm.sv
src/uce_top.sv
tests/uce_assertions.sv
tests/uce_tb.sv

/* run.sh */
#!/usr/bin/env bash
set -e
set -o pipefail
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module uce_tb -f project.f -o uce_sim
./obj_dir/uce_sim 2>&1 | tee sim.log

if grep -q "Checks failed" sim.log; then
  echo "simulation FAILED"
  exit 1
fi
echo "simulation passed"

/* src/uce_cache_pkg.sv */
package uce_cache_pkg;

  // cache geometry
  localparam int PADDR_WIDTH  = 32;
  localparam int SETS         = 4;
  localparam int ASSOC        = 2;
  localparam int BLOCK_WIDTH  = 128;
  localparam int DWORD_WIDTH  = 64;

  // address split is tag | index | offset
  localparam int OFFSET_WIDTH = $clog2(BLOCK_WIDTH / 8);
  localparam int INDEX_WIDTH  = $clog2(SETS);
  localparam int WAY_WIDTH    = $clog2(ASSOC);
  localparam int TAG_WIDTH    = PADDR_WIDTH - INDEX_WIDTH - OFFSET_WIDTH;

  typedef enum logic [1:0] {
    e_miss_load, e_miss_store, e_uc_load, e_uc_store
  } cache_req_e;

  typedef enum logic [1:0] {
    e_tag_set_clear, e_tag_read, e_tag_set_tag
  } tag_op_e;

  typedef enum logic [1:0] {
    e_data_read, e_data_write, e_data_uncached
  } data_op_e;

  typedef enum logic {e_stat_set_clear, e_stat_clear_dirty} stat_op_e;

endpackage

/* src/uce_credit_counter.sv */
`timescale 1ns/1ps

module uce_credit_counter
  import uce_mem_pkg::*;
(
  input  logic clk_i,
  input  logic reset_i,
  input  logic cmd_sent_i,
  input  logic resp_done_i,
  output logic credits_full_o,
  output logic credits_empty_o
);

  logic [CREDIT_WIDTH-1:0] count_r;

  // send and release in one cycle cancel out
  always_ff @(posedge clk_i)
  begin
    if (reset_i)
      count_r <= '0;
    else if (cmd_sent_i && !resp_done_i && !credits_full_o)
      count_r <= count_r + 1'b1;
    else if (resp_done_i && !cmd_sent_i && !credits_empty_o)
      count_r <= count_r - 1'b1;
  end

  assign credits_full_o  = (count_r == CREDIT_WIDTH'(MAX_CREDITS));
  assign credits_empty_o = (count_r == '0);

endmodule

/* src/uce_fsm.sv */
`timescale 1ns/1ps

module uce_fsm
  import uce_cache_pkg::*;
  import uce_mem_pkg::*;
(
  input  logic                   clk_i,
  input  logic                   reset_i,

  input  logic                   cache_req_v_i,
  input  cache_req_e             cache_req_type_i,
  input  logic [PADDR_WIDTH-1:0] cache_req_addr_i,
  input  mem_size_e              cache_req_size_i,
  input  logic [DWORD_WIDTH-1:0] cache_req_data_i,
  output logic                   cache_req_ready_o,
  input  logic                   metadata_v_i,
  input  logic [WAY_WIDTH-1:0]   metadata_way_i,
  input  logic                   metadata_dirty_i,
  output logic                   cache_req_complete_o,

  output logic                   tag_pkt_v_o,
  output tag_op_e                tag_pkt_op_o,
  output logic [INDEX_WIDTH-1:0] tag_pkt_index_o,
  output logic [WAY_WIDTH-1:0]   tag_pkt_way_o,
  output logic [TAG_WIDTH-1:0]   tag_pkt_tag_o,
  input  logic                   tag_pkt_ready_i,

  output logic                   data_pkt_v_o,
  output data_op_e               data_pkt_op_o,
  output logic [INDEX_WIDTH-1:0] data_pkt_index_o,
  output logic [WAY_WIDTH-1:0]   data_pkt_way_o,
  output logic [BLOCK_WIDTH-1:0] data_pkt_data_o,
  input  logic                   data_pkt_ready_i,

  output logic                   stat_pkt_v_o,
  output stat_op_e               stat_pkt_op_o,
  output logic [INDEX_WIDTH-1:0] stat_pkt_index_o,
  output logic [WAY_WIDTH-1:0]   stat_pkt_way_o,
  input  logic                   stat_pkt_ready_i,

  output logic                   mem_cmd_v_o,
  output mem_msg_e               mem_cmd_type_o,
  output logic [PADDR_WIDTH-1:0] mem_cmd_addr_o,
  output mem_size_e              mem_cmd_size_o,
  output logic [WAY_WIDTH-1:0]   mem_cmd_way_o,
  output logic [BLOCK_WIDTH-1:0] mem_cmd_data_o,
  input  logic                   mem_cmd_ready_i,

  input  logic                   mem_resp_v_i,
  input  mem_msg_e               mem_resp_type_i,
  input  logic [PADDR_WIDTH-1:0] mem_resp_addr_i,
  input  logic [WAY_WIDTH-1:0]   mem_resp_way_i,
  input  logic [BLOCK_WIDTH-1:0] mem_resp_data_i,
  output logic                   mem_resp_yumi_o,

  input  logic [TAG_WIDTH-1:0]   victim_tag_i,
  input  logic [BLOCK_WIDTH-1:0] victim_data_i
);

  typedef enum logic [2:0] {
    e_reset, e_clear, e_ready, e_send_req,
    e_writeback_read, e_writeback_req, e_read_wait, e_uc_read_wait
  } state_e;

  state_e                 state_r;
  state_e                 state_n;
  cache_req_e             req_type_r;
  logic [PADDR_WIDTH-1:0] req_addr_r;
  logic                   meta_v_r;
  logic [WAY_WIDTH-1:0]   meta_way_r;
  logic                   meta_dirty_r;
  logic [INDEX_WIDTH-1:0] index_cnt_r;
  logic                   index_up;
  logic                   mem_resp_yumi_lo;

  wire req_accept = cache_req_v_i & cache_req_ready_o;
  wire uc_store_v = cache_req_v_i & (cache_req_type_i == e_uc_store);
  wire miss_v     = (req_type_r == e_miss_load) | (req_type_r == e_miss_store);
  wire index_done = (index_cnt_r == INDEX_WIDTH'(SETS - 1));

  wire store_resp_v = mem_resp_v_i & (mem_resp_type_i inside {e_mem_uc_wr, e_mem_wb});
  wire load_resp_v  = mem_resp_v_i & (mem_resp_type_i inside {e_mem_rd, e_mem_wr, e_mem_uc_rd});

  // metadata bypass
  wire                 meta_v     = metadata_v_i | meta_v_r;
  wire [WAY_WIDTH-1:0] meta_way   = metadata_v_i ? metadata_way_i : meta_way_r;
  wire                 meta_dirty = metadata_v_i ? metadata_dirty_i : meta_dirty_r;

  wire [INDEX_WIDTH-1:0] req_index  = req_addr_r[OFFSET_WIDTH+:INDEX_WIDTH];
  wire [INDEX_WIDTH-1:0] resp_index = mem_resp_addr_i[OFFSET_WIDTH+:INDEX_WIDTH];

  always_ff @(posedge clk_i)
  begin
    if (req_accept)
    begin
      req_type_r <= cache_req_type_i;
      req_addr_r <= cache_req_addr_i;
    end
    if (metadata_v_i)
    begin
      meta_way_r   <= metadata_way_i;
      meta_dirty_r <= metadata_dirty_i;
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      state_r     <= e_reset;
      meta_v_r    <= 1'b0;
      index_cnt_r <= '0;
    end
    else
    begin
      state_r <= state_n;
      if (metadata_v_i)
        meta_v_r <= 1'b1;
      else if (req_accept)
        meta_v_r <= 1'b0;
      if (index_up)
        index_cnt_r <= index_cnt_r + 1'b1;
    end
  end

  assign cache_req_ready_o = (state_r == e_ready) & mem_cmd_ready_i;
  // store responses carry no data and are always taken
  assign mem_resp_yumi_o   = mem_resp_yumi_lo | store_resp_v;

  always_comb
  begin
    state_n              = state_r;
    index_up             = 1'b0;
    cache_req_complete_o = 1'b0;
    mem_resp_yumi_lo     = 1'b0;

    tag_pkt_v_o      = 1'b0;
    tag_pkt_op_o     = e_tag_set_clear;
    tag_pkt_index_o  = '0;
    tag_pkt_way_o    = '0;
    tag_pkt_tag_o    = '0;
    data_pkt_v_o     = 1'b0;
    data_pkt_op_o    = e_data_read;
    data_pkt_index_o = '0;
    data_pkt_way_o   = '0;
    data_pkt_data_o  = '0;
    stat_pkt_v_o     = 1'b0;
    stat_pkt_op_o    = e_stat_set_clear;
    stat_pkt_index_o = '0;
    stat_pkt_way_o   = '0;

    mem_cmd_v_o    = 1'b0;
    mem_cmd_type_o = e_mem_rd;
    mem_cmd_addr_o = '0;
    mem_cmd_size_o = e_size_64;
    mem_cmd_way_o  = '0;
    mem_cmd_data_o = '0;

    case (state_r)
      e_reset:
        state_n = e_clear;
      e_clear:
      begin
        tag_pkt_index_o  = index_cnt_r;
        stat_pkt_index_o = index_cnt_r;
        tag_pkt_v_o      = tag_pkt_ready_i & stat_pkt_ready_i;
        stat_pkt_v_o     = tag_pkt_ready_i & stat_pkt_ready_i;
        index_up         = tag_pkt_v_o;
        cache_req_complete_o = index_done & index_up;
        if (cache_req_complete_o)
          state_n = e_ready;
      end
      e_ready:
      begin
        if (uc_store_v)
        begin
          // uncached stores go out directly
          mem_cmd_type_o = e_mem_uc_wr;
          mem_cmd_addr_o = cache_req_addr_i;
          mem_cmd_size_o = cache_req_size_i;
          mem_cmd_data_o = BLOCK_WIDTH'(cache_req_data_i);
          mem_cmd_v_o    = mem_cmd_ready_i;
        end
        else if (req_accept)
          state_n = e_send_req;
      end
      e_send_req:
      begin
        if (miss_v)
        begin
          mem_cmd_type_o = (req_type_r == e_miss_load) ? e_mem_rd : e_mem_wr;
          mem_cmd_addr_o = {req_addr_r[PADDR_WIDTH-1:OFFSET_WIDTH], OFFSET_WIDTH'(0)};
          mem_cmd_way_o  = meta_way;
          mem_cmd_v_o    = meta_v & mem_cmd_ready_i;
          if (mem_cmd_v_o)
            state_n = meta_dirty ? e_writeback_read : e_read_wait;
        end
        else
        begin
          mem_cmd_type_o = e_mem_uc_rd;
          mem_cmd_addr_o = req_addr_r;
          mem_cmd_size_o = e_size_8;
          mem_cmd_v_o    = mem_cmd_ready_i;
          if (mem_cmd_v_o)
            state_n = e_uc_read_wait;
        end
      end
      e_writeback_read:
      begin
        tag_pkt_op_o     = e_tag_read;
        tag_pkt_index_o  = req_index;
        tag_pkt_way_o    = meta_way;
        data_pkt_op_o    = e_data_read;
        data_pkt_index_o = req_index;
        data_pkt_way_o   = meta_way;
        stat_pkt_op_o    = e_stat_clear_dirty;
        stat_pkt_index_o = req_index;
        stat_pkt_way_o   = meta_way;
        tag_pkt_v_o  = tag_pkt_ready_i & data_pkt_ready_i & stat_pkt_ready_i;
        data_pkt_v_o = tag_pkt_v_o;
        stat_pkt_v_o = tag_pkt_v_o;
        if (tag_pkt_v_o)
          state_n = e_writeback_req;
      end
      e_writeback_req:
      begin
        mem_cmd_type_o = e_mem_wb;
        mem_cmd_addr_o = {victim_tag_i, req_index, OFFSET_WIDTH'(0)};
        mem_cmd_way_o  = meta_way;
        mem_cmd_data_o = victim_data_i;
        mem_cmd_v_o    = mem_cmd_ready_i;
        if (mem_cmd_v_o)
          state_n = e_read_wait;
      end
      e_read_wait:
      begin
        // fill lands in the modified state
        tag_pkt_op_o     = e_tag_set_tag;
        tag_pkt_index_o  = resp_index;
        tag_pkt_way_o    = mem_resp_way_i;
        tag_pkt_tag_o    = mem_resp_addr_i[OFFSET_WIDTH+INDEX_WIDTH+:TAG_WIDTH];
        data_pkt_op_o    = e_data_write;
        data_pkt_index_o = resp_index;
        data_pkt_way_o   = mem_resp_way_i;
        data_pkt_data_o  = mem_resp_data_i;
        tag_pkt_v_o  = load_resp_v & tag_pkt_ready_i & data_pkt_ready_i;
        data_pkt_v_o = tag_pkt_v_o;
        cache_req_complete_o = tag_pkt_v_o;
        mem_resp_yumi_lo     = tag_pkt_v_o;
        if (cache_req_complete_o)
          state_n = e_ready;
      end
      e_uc_read_wait:
      begin
        data_pkt_op_o   = e_data_uncached;
        data_pkt_data_o = mem_resp_data_i;
        data_pkt_v_o    = load_resp_v & data_pkt_ready_i;
        cache_req_complete_o = data_pkt_v_o;
        mem_resp_yumi_lo     = data_pkt_v_o;
        if (cache_req_complete_o)
          state_n = e_ready;
      end
      default:
        state_n = e_reset;
    endcase
  end

endmodule

/* src/uce_mem_pkg.sv */
package uce_mem_pkg;

  typedef enum logic [2:0] {
    e_mem_rd, e_mem_wr, e_mem_uc_rd, e_mem_uc_wr, e_mem_wb
  } mem_msg_e;

  // log2 of the byte count
  typedef enum logic [2:0] {
    e_size_1  = 3'd0,
    e_size_2  = 3'd1,
    e_size_4  = 3'd2,
    e_size_8  = 3'd3,
    e_size_64 = 3'd6
  } mem_size_e;

  // outstanding command limit of the memory network
  localparam int MAX_CREDITS  = 4;
  localparam int CREDIT_WIDTH = 3;

endpackage

/* src/uce_top.sv */
`timescale 1ns/1ps

module uce_top
  import uce_cache_pkg::*;
  import uce_mem_pkg::*;
(
  input  logic                   clk_i,
  input  logic                   reset_i,

  input  logic                   cache_req_v_i,
  input  cache_req_e             cache_req_type_i,
  input  logic [PADDR_WIDTH-1:0] cache_req_addr_i,
  input  mem_size_e              cache_req_size_i,
  input  logic [DWORD_WIDTH-1:0] cache_req_data_i,
  output logic                   cache_req_ready_o,
  input  logic                   metadata_v_i,
  input  logic [WAY_WIDTH-1:0]   metadata_way_i,
  input  logic                   metadata_dirty_i,
  output logic                   cache_req_complete_o,

  output logic                   tag_pkt_v_o,
  output tag_op_e                tag_pkt_op_o,
  output logic [INDEX_WIDTH-1:0] tag_pkt_index_o,
  output logic [WAY_WIDTH-1:0]   tag_pkt_way_o,
  output logic [TAG_WIDTH-1:0]   tag_pkt_tag_o,
  input  logic                   tag_pkt_ready_i,
  input  logic [TAG_WIDTH-1:0]   tag_mem_i,

  output logic                   data_pkt_v_o,
  output data_op_e               data_pkt_op_o,
  output logic [INDEX_WIDTH-1:0] data_pkt_index_o,
  output logic [WAY_WIDTH-1:0]   data_pkt_way_o,
  output logic [BLOCK_WIDTH-1:0] data_pkt_data_o,
  input  logic                   data_pkt_ready_i,
  input  logic [BLOCK_WIDTH-1:0] data_mem_i,

  output logic                   stat_pkt_v_o,
  output stat_op_e               stat_pkt_op_o,
  output logic [INDEX_WIDTH-1:0] stat_pkt_index_o,
  output logic [WAY_WIDTH-1:0]   stat_pkt_way_o,
  input  logic                   stat_pkt_ready_i,

  output logic                   credits_full_o,
  output logic                   credits_empty_o,

  output logic                   mem_cmd_v_o,
  output mem_msg_e               mem_cmd_type_o,
  output logic [PADDR_WIDTH-1:0] mem_cmd_addr_o,
  output mem_size_e              mem_cmd_size_o,
  output logic [WAY_WIDTH-1:0]   mem_cmd_way_o,
  output logic [BLOCK_WIDTH-1:0] mem_cmd_data_o,
  input  logic                   mem_cmd_ready_i,

  input  logic                   mem_resp_v_i,
  input  mem_msg_e               mem_resp_type_i,
  input  logic [PADDR_WIDTH-1:0] mem_resp_addr_i,
  input  logic [WAY_WIDTH-1:0]   mem_resp_way_i,
  input  logic [BLOCK_WIDTH-1:0] mem_resp_data_i,
  output logic                   mem_resp_yumi_o
);

  logic [TAG_WIDTH-1:0]   victim_tag;
  logic [BLOCK_WIDTH-1:0] victim_data;

  uce_fsm u_uce_fsm (
    .clk_i, .reset_i,
    .cache_req_v_i, .cache_req_type_i, .cache_req_addr_i, .cache_req_size_i,
    .cache_req_data_i, .cache_req_ready_o,
    .metadata_v_i, .metadata_way_i, .metadata_dirty_i, .cache_req_complete_o,
    .tag_pkt_v_o, .tag_pkt_op_o, .tag_pkt_index_o, .tag_pkt_way_o, .tag_pkt_tag_o,
    .tag_pkt_ready_i,
    .data_pkt_v_o, .data_pkt_op_o, .data_pkt_index_o, .data_pkt_way_o,
    .data_pkt_data_o, .data_pkt_ready_i,
    .stat_pkt_v_o, .stat_pkt_op_o, .stat_pkt_index_o, .stat_pkt_way_o,
    .stat_pkt_ready_i,
    .mem_cmd_v_o, .mem_cmd_type_o, .mem_cmd_addr_o, .mem_cmd_size_o, .mem_cmd_way_o,
    .mem_cmd_data_o, .mem_cmd_ready_i,
    .mem_resp_v_i, .mem_resp_type_i, .mem_resp_addr_i, .mem_resp_way_i,
    .mem_resp_data_i, .mem_resp_yumi_o,
    .victim_tag_i  (victim_tag),
    .victim_data_i (victim_data)
  );

  uce_victim_buffer u_uce_victim_buffer (
    .clk_i,
    .tag_pkt_v_i   (tag_pkt_v_o),
    .tag_pkt_op_i  (tag_pkt_op_o),
    .data_pkt_v_i  (data_pkt_v_o),
    .data_pkt_op_i (data_pkt_op_o),
    .tag_mem_i,
    .data_mem_i,
    .victim_tag_o  (victim_tag),
    .victim_data_o (victim_data)
  );

  // every command sent takes a credit until its response is consumed
  uce_credit_counter u_uce_credit_counter (
    .clk_i,
    .reset_i,
    .cmd_sent_i  (mem_cmd_v_o),
    .resp_done_i (mem_resp_yumi_o),
    .credits_full_o,
    .credits_empty_o
  );

endmodule

/* src/uce_victim_buffer.sv */
`timescale 1ns/1ps

module uce_victim_buffer
  import uce_cache_pkg::*;
(
  input  logic                   clk_i,
  input  logic                   tag_pkt_v_i,
  input  tag_op_e                tag_pkt_op_i,
  input  logic                   data_pkt_v_i,
  input  data_op_e               data_pkt_op_i,
  input  logic [TAG_WIDTH-1:0]   tag_mem_i,
  input  logic [BLOCK_WIDTH-1:0] data_mem_i,
  output logic [TAG_WIDTH-1:0]   victim_tag_o,
  output logic [BLOCK_WIDTH-1:0] victim_data_o
);

  logic                   tag_read_r;
  logic                   data_read_r;
  logic [TAG_WIDTH-1:0]   tag_r;
  logic [BLOCK_WIDTH-1:0] data_r;

  // memories answer a read one cycle later
  always_ff @(posedge clk_i)
  begin
    tag_read_r  <= tag_pkt_v_i && (tag_pkt_op_i == e_tag_read);
    data_read_r <= data_pkt_v_i && (data_pkt_op_i == e_data_read);
    if (tag_read_r)
      tag_r <= tag_mem_i;
    if (data_read_r)
      data_r <= data_mem_i;
  end

  // bypass so the writeback can leave in the capture cycle
  assign victim_tag_o  = tag_read_r ? tag_mem_i : tag_r;
  assign victim_data_o = data_read_r ? data_mem_i : data_r;

endmodule

/* tests/uce_assertions.sv */
`timescale 1ns/1ps

module uce_assertions (
  input logic clk_i,
  input logic reset_i,
  input logic mem_cmd_v_o,
  input logic mem_cmd_ready_i,
  input logic credits_full_o,
  input logic credits_empty_o,
  input logic data_pkt_v_o,
  input logic data_pkt_ready_i,
  input logic cache_req_complete_o
);

  // valid may only rise while the other side is ready
  cmd_needs_ready: assert property (@(posedge clk_i) disable iff (reset_i)
    mem_cmd_v_o |-> mem_cmd_ready_i)
    else $error("memory command sent without ready");

  credit_flags: assert property (@(posedge clk_i) disable iff (reset_i)
    !(credits_full_o && credits_empty_o))
    else $error("credit counter is full and empty at once");

  data_needs_ready: assert property (@(posedge clk_i) disable iff (reset_i)
    data_pkt_v_o |-> data_pkt_ready_i)
    else $error("data packet sent without ready");

  single_complete: assert property (@(posedge clk_i) disable iff (reset_i)
    cache_req_complete_o |=> !cache_req_complete_o)
    else $error("complete held high for two cycles");

endmodule

bind uce_top uce_assertions u_uce_assertions (.*);

/* tests/uce_tb.sv */
`timescale 1ns/1ps

module uce_tb
  import uce_cache_pkg::*;
  import uce_mem_pkg::*;
;

  localparam int NUM_ROWS      = 6;
  localparam int CREDIT_STORES = 4;
  localparam int CYCLE_LIMIT   = 200 * (NUM_ROWS + CREDIT_STORES) + 100;

  typedef struct {
    cache_req_e             kind;
    logic [PADDR_WIDTH-1:0] addr;
    mem_size_e              size;
    logic [DWORD_WIDTH-1:0] data;
    logic [WAY_WIDTH-1:0]   way;
    logic                   dirty;
  } row_t;

  typedef struct {
    mem_msg_e               kind;
    logic [PADDR_WIDTH-1:0] addr;
    mem_size_e              size;
    logic [BLOCK_WIDTH-1:0] data;
    logic [WAY_WIDTH-1:0]   way;
    logic                   chk_data;
    logic                   chk_way;
  } cmd_t;

  typedef struct {
    mem_msg_e               kind;
    logic [PADDR_WIDTH-1:0] addr;
    logic [WAY_WIDTH-1:0]   way;
    int                     due;
  } resp_t;

  logic clk_i, reset_i;
  logic cache_req_v_i, cache_req_ready_o, cache_req_complete_o;
  cache_req_e cache_req_type_i;
  logic [PADDR_WIDTH-1:0] cache_req_addr_i;
  mem_size_e cache_req_size_i;
  logic [DWORD_WIDTH-1:0] cache_req_data_i;
  logic metadata_v_i, metadata_dirty_i;
  logic [WAY_WIDTH-1:0] metadata_way_i;
  logic tag_pkt_v_o, tag_pkt_ready_i;
  tag_op_e tag_pkt_op_o;
  logic [INDEX_WIDTH-1:0] tag_pkt_index_o, data_pkt_index_o, stat_pkt_index_o;
  logic [WAY_WIDTH-1:0] tag_pkt_way_o, data_pkt_way_o, stat_pkt_way_o;
  logic [TAG_WIDTH-1:0] tag_pkt_tag_o, tag_mem_i;
  logic data_pkt_v_o, data_pkt_ready_i, stat_pkt_v_o, stat_pkt_ready_i;
  data_op_e data_pkt_op_o;
  stat_op_e stat_pkt_op_o;
  logic [BLOCK_WIDTH-1:0] data_pkt_data_o, data_mem_i;
  logic credits_full_o, credits_empty_o;
  logic mem_cmd_v_o, mem_cmd_ready_i;
  mem_msg_e mem_cmd_type_o, mem_resp_type_i;
  logic [PADDR_WIDTH-1:0] mem_cmd_addr_o, mem_resp_addr_i;
  mem_size_e mem_cmd_size_o;
  logic [WAY_WIDTH-1:0] mem_cmd_way_o, mem_resp_way_i;
  logic [BLOCK_WIDTH-1:0] mem_cmd_data_o, mem_resp_data_i;
  logic mem_resp_v_i, mem_resp_yumi_o;

  uce_top u_uce_top (.*);

  // cache memory models and test state
  logic [TAG_WIDTH-1:0]   tag_arr  [SETS][ASSOC];
  logic [BLOCK_WIDTH-1:0] data_arr [SETS][ASSOC];
  row_t  rows [NUM_ROWS];
  cmd_t  exp_q [$];
  resp_t resp_q [$];
  logic  read_pend, hold, pkt_seen;
  logic [INDEX_WIDTH-1:0] rd_idx, fill_idx;
  logic [WAY_WIDTH-1:0]   rd_way, fill_way;
  logic [TAG_WIDTH-1:0]   fill_tag;
  logic [BLOCK_WIDTH-1:0] fill_data, uc_data;
  int cycles, complete_cnt, clear_idx;
  logic [31:0] seed;

  function automatic logic [BLOCK_WIDTH-1:0] block_of(input logic [PADDR_WIDTH-1:0] a);
    return {a ^ 32'hdead_beef, ~a, a + 32'h1234, a[15:0], a[31:16]};
  endfunction

  function automatic int next_delay();
    seed = seed * 32'd1103515245 + 32'd12345;
    return int'(seed[17:16]);
  endfunction

  task automatic report_error(input string msg);
    $display("[ERROR] t=%0t %s", $time, msg);
    $display("Checks failed");
    $fatal(1, "stopped at first error");
  endtask

  initial
  begin
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
  end

  always @(posedge clk_i)
  begin
    cycles++;
    if (cycles > CYCLE_LIMIT)
    begin
      $display("Timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
      $display("Checks failed");
      $fatal(1, "timeout");
    end
  end

  // read data and memory responses
  always @(posedge clk_i)
  begin
    if (read_pend)
    begin
      tag_mem_i  <= tag_arr[rd_idx][rd_way];
      data_mem_i <= data_arr[rd_idx][rd_way];
      read_pend  = 1'b0;
    end
    if (resp_q.size() > 0 && !hold && resp_q[0].due <= cycles)
    begin
      mem_resp_v_i    <= 1'b1;
      mem_resp_type_i <= resp_q[0].kind;
      mem_resp_addr_i <= resp_q[0].addr;
      mem_resp_way_i  <= resp_q[0].way;
      mem_resp_data_i <= block_of(resp_q[0].addr);
    end
    else
      mem_resp_v_i <= 1'b0;
  end

  // outputs are settled at the falling edge
  always @(negedge clk_i)
  begin
    cmd_t c;
    if (!reset_i)
    begin
      if (tag_pkt_v_o && tag_pkt_op_o == e_tag_set_clear)
      begin
        assert (stat_pkt_v_o && stat_pkt_op_o == e_stat_set_clear
                && tag_pkt_index_o == clear_idx && stat_pkt_index_o == clear_idx)
        else report_error($sformatf("bad clear packet for index %0d", clear_idx));
        assert (cache_req_complete_o == (clear_idx == SETS - 1))
        else report_error("complete pulse misplaced in clear sweep");
        for (int w = 0; w < ASSOC; w++)
          tag_arr[tag_pkt_index_o][w] = '0;
        clear_idx++;
      end
      if (tag_pkt_v_o && tag_pkt_op_o == e_tag_set_tag)
      begin
        assert (data_pkt_v_o && data_pkt_op_o == e_data_write && cache_req_complete_o
                && tag_pkt_tag_o == fill_tag && tag_pkt_index_o == fill_idx
                && tag_pkt_way_o == fill_way && data_pkt_index_o == fill_idx
                && data_pkt_way_o == fill_way && data_pkt_data_o == fill_data)
        else report_error($sformatf("bad fill, tag %h index %0d", tag_pkt_tag_o,
                                    tag_pkt_index_o));
        tag_arr[fill_idx][fill_way]  = tag_pkt_tag_o;
        data_arr[fill_idx][fill_way] = data_pkt_data_o;
        pkt_seen = 1'b1;
      end
      if (tag_pkt_v_o && tag_pkt_op_o == e_tag_read)
      begin
        assert (data_pkt_v_o && data_pkt_op_o == e_data_read
                && tag_pkt_index_o == fill_idx && tag_pkt_way_o == fill_way
                && data_pkt_index_o == fill_idx && data_pkt_way_o == fill_way
                && stat_pkt_v_o && stat_pkt_op_o == e_stat_clear_dirty
                && stat_pkt_index_o == fill_idx && stat_pkt_way_o == fill_way)
        else report_error("victim read targets the wrong line");
        read_pend = 1'b1;
        rd_idx    = tag_pkt_index_o;
        rd_way    = tag_pkt_way_o;
      end
      if (data_pkt_v_o && data_pkt_op_o == e_data_uncached)
      begin
        assert (data_pkt_data_o == uc_data && cache_req_complete_o)
        else report_error($sformatf("uncached load data %h", data_pkt_data_o));
        pkt_seen = 1'b1;
      end
      if (mem_cmd_v_o)
      begin
        assert (exp_q.size() > 0)
        else report_error("unexpected memory command");
        c = exp_q.pop_front();
        assert (mem_cmd_type_o == c.kind && mem_cmd_addr_o == c.addr
                && mem_cmd_size_o == c.size
                && (!c.chk_data || mem_cmd_data_o == c.data)
                && (!c.chk_way || mem_cmd_way_o == c.way))
        else report_error($sformatf("command %s addr %h, expected %s addr %h",
                                    mem_cmd_type_o.name(), mem_cmd_addr_o,
                                    c.kind.name(), c.addr));
        resp_q.push_back('{mem_cmd_type_o, mem_cmd_addr_o, mem_cmd_way_o,
                           cycles + 1 + next_delay()});
      end
      if (mem_resp_v_i && mem_resp_yumi_o)
        void'(resp_q.pop_front());
      if (cache_req_complete_o)
        complete_cnt++;
    end
  end

  task automatic run_row(input row_t r);
    logic [INDEX_WIDTH-1:0] idx;
    logic [PADDR_WIDTH-1:0] blk;
    int start;
    idx      = r.addr[OFFSET_WIDTH+:INDEX_WIDTH];
    blk      = {r.addr[PADDR_WIDTH-1:OFFSET_WIDTH], 4'h0};
    start    = complete_cnt;
    pkt_seen = 1'b0;
    case (r.kind)
      e_uc_store:
        exp_q.push_back('{e_mem_uc_wr, r.addr, r.size, BLOCK_WIDTH'(r.data), '0, 1'b1, 1'b0});
      e_uc_load:
      begin
        exp_q.push_back('{e_mem_uc_rd, r.addr, e_size_8, '0, '0, 1'b0, 1'b0});
        uc_data = block_of(r.addr);
      end
      default:
      begin
        exp_q.push_back('{(r.kind == e_miss_load) ? e_mem_rd : e_mem_wr, blk, e_size_64,
                          '0, r.way, 1'b0, 1'b1});
        if (r.dirty)
          exp_q.push_back('{e_mem_wb, {tag_arr[idx][r.way], idx, 4'h0}, e_size_64,
                            data_arr[idx][r.way], r.way, 1'b1, 1'b1});
        fill_idx  = idx;
        fill_way  = r.way;
        fill_tag  = r.addr[PADDR_WIDTH-1:OFFSET_WIDTH+INDEX_WIDTH];
        fill_data = block_of(blk);
      end
    endcase
    @(posedge clk_i);
    cache_req_v_i    <= 1'b1;
    cache_req_type_i <= r.kind;
    cache_req_addr_i <= r.addr;
    cache_req_size_i <= r.size;
    cache_req_data_i <= r.data;
    do
      @(negedge clk_i);
    while (!cache_req_ready_o);
    @(posedge clk_i);
    cache_req_v_i <= 1'b0;
    if (r.kind == e_miss_load || r.kind == e_miss_store)
    begin
      metadata_v_i     <= 1'b1;
      metadata_way_i   <= r.way;
      metadata_dirty_i <= r.dirty;
      @(posedge clk_i);
      metadata_v_i <= 1'b0;
    end
    if (r.kind == e_uc_store)
    begin
      while (resp_q.size() != 0 && !hold)
        @(negedge clk_i);
      assert (complete_cnt == start)
      else report_error("uncached store raised complete");
    end
    else
    begin
      while (complete_cnt == start)
        @(negedge clk_i);
      @(negedge clk_i);
      assert (complete_cnt == start + 1)
      else report_error("more than one complete pulse");
      assert (pkt_seen)
      else report_error("complete without a fill or uncached data packet");
    end
    assert (exp_q.size() == 0)
    else report_error($sformatf("%0d expected commands never sent", exp_q.size()));
  endtask

  initial
  begin
    row_t st;
    reset_i = 1'b1;
    cache_req_v_i = 1'b0;
    cache_req_type_i = e_miss_load;
    cache_req_addr_i = '0;
    cache_req_size_i = e_size_8;
    cache_req_data_i = '0;
    metadata_v_i = 1'b0;
    metadata_way_i = '0;
    metadata_dirty_i = 1'b0;
    tag_pkt_ready_i = 1'b1;
    data_pkt_ready_i = 1'b1;
    stat_pkt_ready_i = 1'b1;
    mem_cmd_ready_i = 1'b1;
    tag_mem_i = '0;
    data_mem_i = '0;
    mem_resp_v_i = 1'b0;
    mem_resp_type_i = e_mem_rd;
    mem_resp_addr_i = '0;
    mem_resp_way_i = '0;
    mem_resp_data_i = '0;
    read_pend = 1'b0;
    hold = 1'b0;
    pkt_seen = 1'b0;
    seed = 32'd82;
    cycles = 0;
    complete_cnt = 0;
    clear_idx = 0;

    // kind, address, size, data, way, dirty
    rows[0] = '{e_uc_store,   32'h8000_0010, e_size_4,  64'h1122_3344_5566_7788, 1'b0, 1'b0};
    rows[1] = '{e_miss_load,  32'h0000_1020, e_size_64, 64'h0, 1'b1, 1'b0};
    rows[2] = '{e_miss_store, 32'h0000_2030, e_size_64, 64'h0, 1'b0, 1'b0};
    // evicts the line filled by row 1
    rows[3] = '{e_miss_load,  32'h0000_5024, e_size_64, 64'h0, 1'b1, 1'b1};
    rows[4] = '{e_uc_load,    32'h9000_0008, e_size_8,  64'h0, 1'b0, 1'b0};
    rows[5] = '{e_uc_store,   32'h9000_0100, e_size_8,  64'hcafe_0000_f00d_0001, 1'b0, 1'b0};

    repeat (10) @(posedge clk_i);
    reset_i <= 1'b0;
    while (clear_idx < SETS)
      @(negedge clk_i);
    @(negedge clk_i);
    assert (complete_cnt == 1 && credits_empty_o)
    else report_error($sformatf("clear sweep gave %0d complete pulses", complete_cnt));

    foreach (rows[i])
      run_row(rows[i]);

    hold = 1'b1;
    for (int i = 0; i < CREDIT_STORES; i++)
    begin
      st = '{e_uc_store, 32'h7000_0000 + 32'(i * 8), e_size_8, 64'(i + 1), 1'b0, 1'b0};
      run_row(st);
    end
    @(negedge clk_i);
    assert (credits_full_o)
    else report_error("credits not full with four stores in flight");
    hold = 1'b0;
    while (!credits_empty_o)
      @(negedge clk_i);
    assert (resp_q.size() == 0)
    else report_error("responses left unconsumed");

    $display("All checks passed");
    $finish;
  end

endmodule
